//--- common/tune_pkg.sv
package tune_pkg;

    // Field widths
    localparam int PERIOD_W = 12;  // Note period in clocks
    localparam int DUR_W    = 7;   // Note duration in units
    localparam int ADDR_W   = 4;   // 16 ROM words
    localparam int WORD_W   = 20;  // One ROM word
    localparam int DATA_W   = 8;   // Host data bus

    // Tune start addresses in the ROM
    localparam logic [ADDR_W-1:0] TUNE0_BASE = 4'd0;
    localparam logic [ADDR_W-1:0] TUNE1_BASE = 4'd8;

    // Host register map, one address bit
    localparam logic REG_CTRL   = 1'b0;
    localparam logic REG_STATUS = 1'b1;

    // REG_CTRL bit positions
    localparam int CTRL_START_BIT = 0;  // Self-clearing
    localparam int CTRL_STOP_BIT  = 1;  // Self-clearing
    localparam int CTRL_MUTE_BIT  = 2;
    localparam int CTRL_SEL_BIT   = 3;

    // REG_STATUS bit positions
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_ADDR_LSB = 4;  // cur_addr in bits 7:4

    typedef enum logic [1:0] {
        OP_END  = 2'd0,  // Stop playback
        OP_JUMP = 2'd1   // Continue at target
    } ctrl_op_e;

    // Tag 0, period 0 is a rest
    typedef struct packed {
        logic                tag;
        logic [PERIOD_W-1:0] period;
        logic [DUR_W-1:0]    dur;
    } note_word_t;

    // Tag 1
    typedef struct packed {
        logic                       tag;
        ctrl_op_e                   op;
        logic [ADDR_W-1:0]          target;
        logic [WORD_W-4-ADDR_W:0]   pad;
    } ctrl_word_t;

    // Same 20 bits, the tag in the MSB picks the view
    typedef union packed {
        note_word_t note;
        ctrl_word_t ctrl;
    } rom_word_u;

    function automatic rom_word_u mk_note(input logic [PERIOD_W-1:0] period,
                                          input logic [DUR_W-1:0] dur);
        rom_word_u w;
        w             = '0;
        w.note.tag    = 1'b0;
        w.note.period = period;
        w.note.dur    = dur;
        return w;
    endfunction

    function automatic rom_word_u mk_ctrl(input ctrl_op_e op,
                                          input logic [ADDR_W-1:0] target);
        rom_word_u w;
        w             = '0;  // Pad stays zero
        w.ctrl.tag    = 1'b1;
        w.ctrl.op     = op;
        w.ctrl.target = target;
        return w;
    endfunction

endpackage

//--- rtl/tune_rom.sv
`timescale 1ns/100ps

module tune_rom (
    input  logic [tune_pkg::ADDR_W-1:0] addr,
    output tune_pkg::rom_word_u         word
);

    import tune_pkg::*;

    // Fixed table, answered in the same cycle
    always_comb begin
        case (addr)
            // Tune 0 at base 0
            4'd0:    word = mk_note(12'd10, 7'd8);
            4'd1:    word = mk_note(12'd16, 7'd6);
            4'd2:    word = mk_note(12'd12, 7'd10);
            4'd3:    word = mk_note(12'd0,  7'd4);   // Rest
            4'd4:    word = mk_ctrl(OP_END, 4'd0);

            // Tune 1 at base 8, loops forever
            4'd8:    word = mk_note(12'd20, 7'd5);
            4'd9:    word = mk_note(12'd14, 7'd3);
            4'd10:   word = mk_ctrl(OP_JUMP, TUNE1_BASE);

            // Unused slots stop playback if ever reached
            default: word = mk_ctrl(OP_END, 4'd0);
        endcase
    end

endmodule

//--- rtl/tone_gen.sv
`timescale 1ns/100ps

module tone_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [tune_pkg::PERIOD_W-1:0] period,     // Clocks per cycle, 0 for a rest
    input  logic                          note_load,  // New note starts next cycle
    input  logic                          mute,
    input  logic                          active,     // Sequencer busy
    output logic                          piezo,
    output logic                          piezo_n
);

    import tune_pkg::*;

    logic [PERIOD_W-1:0] cnt;       // Position within the waveform period
    logic                wrap;      // Last count of the period
    logic                tone_hi;   // First half of the period
    logic                sound_en;

    // Zero period never counts
    assign wrap = (period == '0) || (cnt == period - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (note_load || !active) begin
            cnt <= '0;  // Phase restarts with every note
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tone_hi  = (cnt < (period >> 1));  // floor(P/2) high, rest low
    assign sound_en = active && !mute && (period != '0);

    // Both legs low when silent, otherwise complementary
    assign piezo   = sound_en & tone_hi;
    assign piezo_n = sound_en & ~tone_hi;

endmodule

//--- rtl/note_sequencer.sv
`timescale 1ns/100ps

module note_sequencer #(
    parameter int DUR_SHIFT = 20  // One duration unit is 2**DUR_SHIFT clocks
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_pulse,
    input  logic                          stop_pulse,
    input  logic                          tune_sel,
    input  tune_pkg::rom_word_u           rom_word,
    output logic [tune_pkg::ADDR_W-1:0]   rom_addr,
    output logic [tune_pkg::PERIOD_W-1:0] period,
    output logic                          note_load,  // FETCH to PLAY edge
    output logic                          busy,
    output logic [tune_pkg::ADDR_W-1:0]   cur_addr
);

    import tune_pkg::*;

    localparam int CNT_W = DUR_W + DUR_SHIFT;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,  // One cycle per ROM word
        S_PLAY    // Note or rest running
    } seq_state_t;

    seq_state_t state, state_nxt;

    logic [ADDR_W-1:0]   addr_q, addr_nxt;
    logic [PERIOD_W-1:0] period_q;
    logic [CNT_W-1:0]    dur_cnt;     // Clocks left in PLAY, minus one
    logic [CNT_W-1:0]    note_ticks;  // dur scaled to clocks
    logic                is_note;
    logic                play_done;

    // Tag bit picks the union view
    assign is_note    = (rom_word.note.tag == 1'b0);
    assign note_ticks = CNT_W'(rom_word.note.dur) << DUR_SHIFT;
    assign play_done  = (dur_cnt == '0);

    always_comb begin
        state_nxt = state;
        addr_nxt  = addr_q;
        note_load = 1'b0;
        case (state)
            S_IDLE: begin
                if (start_pulse) begin  // Start while busy never reaches here
                    addr_nxt  = tune_sel ? TUNE1_BASE : TUNE0_BASE;
                    state_nxt = S_FETCH;
                end
            end
            S_FETCH: begin
                if (is_note) begin
                    note_load = 1'b1;
                    state_nxt = S_PLAY;
                end else if (rom_word.ctrl.op == OP_JUMP) begin
                    addr_nxt = rom_word.ctrl.target;  // Fetch target next cycle
                end else begin
                    state_nxt = S_IDLE;  // OP_END and unknown ops
                end
            end
            S_PLAY: begin
                if (play_done) begin
                    addr_nxt  = addr_q + 1'b1;
                    state_nxt = S_FETCH;
                end
            end
            default: state_nxt = S_IDLE;
        endcase

        // Stop overrides everything
        if (stop_pulse) begin
            state_nxt = S_IDLE;
            note_load = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            addr_q <= '0;
        end else begin
            state  <= state_nxt;
            addr_q <= addr_nxt;
        end
    end

    // Note payload, loaded when a note word is fetched
    always_ff @(posedge clk) begin
        if (note_load) begin
            period_q <= rom_word.note.period;
            dur_cnt  <= note_ticks - 1'b1;  // ROM holds no zero durations
        end else if (state == S_PLAY) begin
            dur_cnt <= dur_cnt - 1'b1;
        end
    end

    assign rom_addr = addr_q;
    assign cur_addr = addr_q;            // Status view of the same pointer
    assign period   = period_q;          // Held through PLAY
    assign busy     = (state != S_IDLE);

endmodule

//--- rtl/tune_regs.sv
`timescale 1ns/100ps

module tune_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic                        we,
    input  logic                        addr,
    input  logic [tune_pkg::DATA_W-1:0] wdata,
    input  logic                        busy,
    input  logic [tune_pkg::ADDR_W-1:0] cur_addr,
    output logic                        ack,
    output logic [tune_pkg::DATA_W-1:0] rdata,
    output logic                        start_pulse,
    output logic                        stop_pulse,
    output logic                        mute,
    output logic                        tune_sel
);

    import tune_pkg::*;

    typedef enum logic {
        HS_WAIT,  // ack low, waiting for req
        HS_ACK    // ack high, waiting for req to drop
    } hs_state_t;

    hs_state_t         hs_state;
    logic              accept;     // New request seen this cycle
    logic [DATA_W-1:0] ctrl_rd;    // REG_CTRL read view
    logic [DATA_W-1:0] status_rd;  // REG_STATUS read view

    assign accept = req && (hs_state == HS_WAIT);
    assign ack    = (hs_state == HS_ACK);

    // start and stop always read back as zero
    always_comb begin
        ctrl_rd                = '0;
        ctrl_rd[CTRL_MUTE_BIT] = mute;
        ctrl_rd[CTRL_SEL_BIT]  = tune_sel;
    end

    always_comb begin
        status_rd                           = '0;
        status_rd[STAT_BUSY_BIT]            = busy;
        status_rd[STAT_ADDR_LSB +: ADDR_W]  = cur_addr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state    <= HS_WAIT;
            start_pulse <= 1'b0;
            stop_pulse  <= 1'b0;
            mute        <= 1'b0;
            tune_sel    <= 1'b0;
        end else begin
            start_pulse <= 1'b0;  // Pulses last one cycle
            stop_pulse  <= 1'b0;
            case (hs_state)
                HS_WAIT: begin
                    if (accept) begin
                        hs_state <= HS_ACK;
                        if (we && addr == REG_CTRL) begin  // Status is read-only
                            start_pulse <= wdata[CTRL_START_BIT];
                            stop_pulse  <= wdata[CTRL_STOP_BIT];
                            mute        <= wdata[CTRL_MUTE_BIT];
                            tune_sel    <= wdata[CTRL_SEL_BIT];
                        end
                    end
                end
                HS_ACK: if (!req) hs_state <= HS_WAIT;
                default: hs_state <= HS_WAIT;
            endcase
        end
    end

    // Read data captured on the accepting edge
    always_ff @(posedge clk) begin
        if (accept && !we) begin
            rdata <= (addr == REG_STATUS) ? status_rd : ctrl_rd;
        end
    end

endmodule

//--- rtl/buzzer_top.sv
`timescale 1ns/100ps

module buzzer_top #(
    parameter int DUR_SHIFT = 20  // Clocks per duration unit, as a power of two
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic                        we,
    input  logic                        addr,
    input  logic [tune_pkg::DATA_W-1:0] wdata,
    output logic                        ack,
    output logic [tune_pkg::DATA_W-1:0] rdata,
    output logic                        piezo,
    output logic                        piezo_n
);

    import tune_pkg::*;

    // Register block to sequencer
    logic start_pulse;
    logic stop_pulse;
    logic tune_sel;
    logic mute;
    logic busy;
    logic [ADDR_W-1:0] cur_addr;

    // Sequencer to ROM and tone generator
    logic [ADDR_W-1:0]   rom_addr;
    rom_word_u           rom_word;
    logic [PERIOD_W-1:0] period;
    logic                note_load;

    tune_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .cur_addr    (cur_addr),
        .ack         (ack),
        .rdata       (rdata),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .mute        (mute),
        .tune_sel    (tune_sel)
    );

    note_sequencer #(
        .DUR_SHIFT (DUR_SHIFT)
    ) seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .tune_sel    (tune_sel),
        .rom_word    (rom_word),
        .rom_addr    (rom_addr),
        .period      (period),
        .note_load   (note_load),
        .busy        (busy),
        .cur_addr    (cur_addr)
    );

    tune_rom rom_i (
        .addr (rom_addr),
        .word (rom_word)
    );

    // Silent whenever the sequencer is idle
    tone_gen tone_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .period    (period),
        .note_load (note_load),
        .mute      (mute),
        .active    (busy),
        .piezo     (piezo),
        .piezo_n   (piezo_n)
    );

endmodule

//--- bench/buzzer_tb.sv
`timescale 1ns/100ps

module buzzer_tb;

    import tune_pkg::*;

    localparam int DUR_SHIFT      = 2;     // 4 clocks per duration unit
    localparam int TIMEOUT_CYCLES = 3000;  // Two tune 0 runs near 240, tune 1 near 100, wide margin
    localparam int K_NOTE         = 0;
    localparam int K_END          = 1;
    localparam int K_JUMP         = 2;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    logic              addr;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              piezo;
    logic              piezo_n;

    // Reference copy of the tune table
    int m_kind   [16];
    int m_period [16];
    int m_dur    [16];
    int m_target [16];

    logic  chk_busy;    // Compare busy with exp_busy
    logic  chk_tone;    // Compare outputs with exp_hi/exp_lo
    logic  in_loop;     // Tune 1 running
    logic  exp_busy;
    logic  exp_hi;
    logic  exp_lo;
    int    last_addr;   // Address of the word that ended the tune
    int    value_errs;
    int    proto_errs;
    int    cycles;
    string test_name;

    buzzer_top #(.DUR_SHIFT(DUR_SHIFT)) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .piezo   (piezo),
        .piezo_n (piezo_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run never reached its end", cycles);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("Test failed");
        $finish;
    end

    // Host handshake rules
    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
        else begin
            proto_errs++;
            $display("%s: ack rose while req was low", test_name);
        end
    assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
        else begin
            proto_errs++;
            $display("%s: ack fell while req was still high", test_name);
        end
    assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |-> !ack)
        else begin
            proto_errs++;
            $display("%s: ack already high when a new req started", test_name);
        end

    // Cycle checks against the model
    assert property (@(posedge clk) disable iff (!rst_n)
        chk_tone |-> ({piezo, piezo_n} == {exp_hi, exp_lo}))
        else begin
            value_errs++;
            $display("FAILED %s: piezo/piezo_n expected %b%b, actual %b%b", test_name,
                     $sampled(exp_hi), $sampled(exp_lo), $sampled(piezo), $sampled(piezo_n));
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        chk_busy |-> (dut_i.busy == exp_busy))
        else begin
            value_errs++;
            $display("FAILED %s: busy expected %b, actual %b", test_name,
                     $sampled(exp_busy), $sampled(dut_i.busy));
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        in_loop |-> (dut_i.cur_addr >= 4'd8 && dut_i.cur_addr <= 4'd10))
        else begin
            value_errs++;
            $display("FAILED %s: cur_addr expected 8 to 10, actual %0d", test_name,
                     $sampled(dut_i.cur_addr));
        end

    task automatic set_word(input int a, input int kind, input int p, input int d,
                            input int tgt);
        m_kind[a]   = kind;
        m_period[a] = p;
        m_dur[a]    = d;
        m_target[a] = tgt;
    endtask

    task automatic load_model();
        int a;
        for (a = 0; a < 16; a++) begin
            set_word(a, K_END, 0, 0, 0);  // Unused words end the tune
        end
        set_word(0, K_NOTE, 10, 8, 0);
        set_word(1, K_NOTE, 16, 6, 0);
        set_word(2, K_NOTE, 12, 10, 0);
        set_word(3, K_NOTE, 0, 4, 0);     // Rest
        set_word(8, K_NOTE, 20, 5, 0);
        set_word(9, K_NOTE, 14, 3, 0);
        set_word(10, K_JUMP, 0, 0, 8);
    endtask

    // Cycles for one pass through a tune, up to its END or JUMP word
    function automatic int loop_len(input int base);
        int   a;
        int   n;
        logic done;
        a    = base;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            n = n + 1;  // Fetch
            if (m_kind[a] == K_NOTE) begin
                n = n + (m_dur[a] << DUR_SHIFT);
                a = a + 1;
            end else begin
                done = 1'b1;
            end
        end
        return n;
    endfunction

    task automatic expect_value(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        assert (act === exp)
            else begin
                value_errs++;
                $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
            end
    endtask

    task automatic write_reg(input logic a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        req   = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        while (!ack) @(negedge clk);
        req = 1'b0;
        we  = 1'b0;
        while (ack) @(negedge clk);
    endtask

    task automatic read_reg(input logic a, output logic [DATA_W-1:0] d);
        @(negedge clk);
        req  = 1'b1;
        we   = 1'b0;
        addr = a;
        while (!ack) @(negedge clk);
        d   = rdata;  // Held while ack is high
        req = 1'b0;
        while (ack) @(negedge clk);
    endtask

    // Square wave phase t of a note with period p
    task automatic set_tone(input int p, input int t, input logic muted);
        logic hi;
        if (p == 0 || muted) begin
            exp_hi = 1'b0;
            exp_lo = 1'b0;
        end else begin
            hi     = ((t % p) < (p / 2));
            exp_hi = hi;
            exp_lo = !hi;
        end
        chk_tone = 1'b1;
    endtask

    // Walks the model table in step with the DUT, from the start write's ack
    task automatic model_tune(input logic sel, input logic muted);
        int   a;
        int   t;
        logic done;
        a    = sel ? 8 : 0;
        done = 1'b0;
        while (!ack) @(negedge clk);
        @(negedge clk);  // Start pulse cycle over, first fetch
        exp_busy = 1'b1;
        while (!done) begin
            chk_tone = 1'b0;  // Fetch cycle, waveform not defined
            @(negedge clk);
            if (m_kind[a] == K_NOTE) begin
                for (t = 0; t < (m_dur[a] << DUR_SHIFT); t++) begin
                    set_tone(m_period[a], t, muted);
                    @(negedge clk);
                end
                a = a + 1;
            end else if (m_kind[a] == K_JUMP) begin
                a = m_target[a];
            end else begin
                done = 1'b1;
            end
        end
        last_addr = a;
        exp_busy  = 1'b0;
        exp_hi    = 1'b0;
        exp_lo    = 1'b0;
        chk_tone  = 1'b1;  // Idle and silent from here
    endtask

    initial begin
        logic [DATA_W-1:0] d;
        rst_n      = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = 1'b0;
        wdata      = '0;
        chk_busy   = 1'b1;
        chk_tone   = 1'b1;
        in_loop    = 1'b0;
        exp_busy   = 1'b0;
        exp_hi     = 1'b0;
        exp_lo     = 1'b0;
        last_addr  = 0;
        value_errs = 0;
        proto_errs = 0;
        test_name  = "reset";
        load_model();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        expect_value("reset outputs", 8'h00, {5'd0, ack, piezo, piezo_n});
        read_reg(REG_STATUS, d);
        expect_value("reset status", 8'h00, d);

        test_name = "tune0";
        fork
            model_tune(1'b0, 1'b0);
            write_reg(REG_CTRL, 8'h01);  // Start tune 0
        join
        read_reg(REG_STATUS, d);
        expect_value("tune0 end status", {4'(last_addr), 4'h0}, d);

        test_name = "mute";
        fork
            model_tune(1'b0, 1'b1);
            begin
                write_reg(REG_CTRL, 8'h05);  // Start with mute
                read_reg(REG_CTRL, d);
                expect_value("mute ctrl readback", 8'h04, d);
                repeat (40) @(negedge clk);
                read_reg(REG_STATUS, d);
                expect_value("mute busy", 8'h01, d & 8'h01);
            end
        join
        read_reg(REG_STATUS, d);
        expect_value("mute end busy", 8'h00, d & 8'h01);

        test_name = "jump_stop";
        chk_busy  = 1'b0;  // Endless tune
        chk_tone  = 1'b0;
        write_reg(REG_CTRL, 8'h09);  // Start tune 1
        in_loop = 1'b1;
        read_reg(REG_CTRL, d);
        expect_value("tune1 ctrl readback", 8'h08, d);
        repeat (2 * loop_len(8)) @(negedge clk);
        read_reg(REG_STATUS, d);
        expect_value("tune1 busy", 8'h01, d & 8'h01);
        expect_value("tune1 addr in range", 8'h01,
                     (d[7:4] >= 4'd8 && d[7:4] <= 4'd10) ? 8'h01 : 8'h00);
        write_reg(REG_CTRL, 8'h0A);  // Stop, tune 1 still selected
        chk_busy = 1'b1;  // Idle expectations still set from the mute run
        chk_tone = 1'b1;
        in_loop  = 1'b0;
        repeat (8) @(negedge clk);
        read_reg(REG_STATUS, d);
        expect_value("stop status busy", 8'h00, d & 8'h01);
        read_reg(REG_CTRL, d);
        expect_value("stop ctrl readback", 8'h08, d);  // Stop bit reads as zero

        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- buzzer_top.f
common/tune_pkg.sv
rtl/tune_rom.sv
rtl/tone_gen.sv
rtl/note_sequencer.sv
rtl/tune_regs.sv
rtl/buzzer_top.sv
bench/buzzer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module buzzer_tb -f buzzer_top.f \
    -o buzzer_sim > build.log 2>&1 \
    && ./obj_dir/buzzer_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0
